// ==== Bender.yml ====
package:
  name: cp15

sources:
  - rtl/cp15Pkg.sv
  - rtl/cp15Decode.sv
  - rtl/cp15Execute.sv
  - rtl/cp15Result.sv
  - rtl/cp15Top.sv
  - target: test
    files:
      - tests/cp15Tb.sv

// ==== project.f ====
rtl/cp15Pkg.sv
rtl/cp15Decode.sv
rtl/cp15Execute.sv
rtl/cp15Result.sv
rtl/cp15Top.sv
tests/cp15Tb.sv

// ==== rtl/cp15Decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module cp15Decode
  import cp15Pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cpEn,
  input  cpWord_u     cpInstr,
  input  logic [31:0] wrData,
  output logic [2:0]  opClass,
  output logic [3:0]  regIdx,
  output logic [2:0]  maintOp,
  output logic [31:0] opData
);

  logic       isCoproc;
  logic       isSysCp;
  logic       isCdp;
  logic       badOpc1;
  logic       regMapped;
  logic       isMaintReg;
  logic [2:0] crmMaint;
  logic [2:0] nextClass;
  logic [2:0] nextMaint;

  // Format checks through the CDP view
  assign isCoproc = (cpInstr.dataOp.classBits == CLASS_COPROC);
  assign isCdp    = ~cpInstr.dataOp.zero;

  // Field checks through the MCR/MRC view
  assign isSysCp  = (cpInstr.regXfer.cpNum == CP_NUM_SYS);
  assign badOpc1  = (cpInstr.regXfer.opc1 != 3'd0);

  assign regMapped = cpInstr.regXfer.crn inside {REG_ID, REG_CTRL, REG_TBASE, REG_DOMAIN,
                                                 REG_FSR, REG_FAR, REG_CACHE, REG_TLB};

  // c7 and c8 carry operations, not storage
  assign isMaintReg = (cpInstr.regXfer.crn == REG_CACHE) ||
                      (cpInstr.regXfer.crn == REG_TLB);

  // crm selects the maintenance action
  always_comb begin
    crmMaint = MNT_NONE;
    if (cpInstr.regXfer.crn == REG_CACHE) begin
      case (cpInstr.regXfer.crm)
        4'd5:    crmMaint = MNT_FLUSH_I;
        4'd6:    crmMaint = MNT_FLUSH_D;
        4'd7:    crmMaint = MNT_FLUSH_ID;
        4'd10:   crmMaint = MNT_CLEAN_D;
        default: crmMaint = MNT_NONE;
      endcase
    end else if (cpInstr.regXfer.crn == REG_TLB) begin
      case (cpInstr.regXfer.crm)
        4'd5:    crmMaint = MNT_TLB_I;
        4'd6:    crmMaint = MNT_TLB_D;
        4'd7:    crmMaint = MNT_TLB_ID;
        default: crmMaint = MNT_NONE;
      endcase
    end
  end

  // Classification, undefined unless every check passes
  always_comb begin
    nextClass = OP_NONE;
    nextMaint = MNT_NONE;
    if (cpEn) begin
      if (!isCoproc || !isSysCp || isCdp || badOpc1 || !regMapped) begin
        nextClass = OP_UNDEF;
      end else if (cpInstr.regXfer.load) begin
        // MRC, nothing to read back from c7 or c8
        nextClass = isMaintReg ? OP_UNDEF : OP_READ;
      end else if (cpInstr.regXfer.crn == REG_ID) begin
        // ID register is read only
        nextClass = OP_UNDEF;
      end else if (isMaintReg) begin
        if (crmMaint == MNT_NONE) begin
          nextClass = OP_UNDEF;
        end else begin
          nextClass = OP_MAINT;
          nextMaint = crmMaint;
        end
      end else begin
        nextClass = OP_WRITE;
      end
    end
  end

  // Stage register, control part
  always_ff @(posedge clk) begin
    if (rst) begin
      opClass <= OP_NONE;
      maintOp <= MNT_NONE;
    end else begin
      opClass <= nextClass;
      maintOp <= nextMaint;
    end
  end

  // Payload travels alongside
  always_ff @(posedge clk) begin
    regIdx <= cpInstr.regXfer.crn;
    opData <= wrData;
  end

  // A maintenance code only rides with a maintenance class
  assert property (@(posedge clk) disable iff (rst)
    (opClass != OP_MAINT) |-> (maintOp == MNT_NONE));

endmodule

`default_nettype wire

// ==== rtl/cp15Execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module cp15Execute
  import cp15Pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [2:0]  opClass,
  input  logic [3:0]  regIdx,
  input  logic [2:0]  maintOp,
  input  logic [31:0] opData,
  input  logic        mmuFault,
  input  logic [7:0]  faultStatus,
  input  logic [31:0] faultAddr,
  output logic [31:0] control,
  output logic [31:0] tbase,
  output logic [31:0] domain,
  output logic [2:0]  exClass,
  output logic [2:0]  exMaint,
  output logic [31:0] exData
);

  // Fault records kept inside the coprocessor
  logic [FSR_W-1:0] fsr;
  logic [31:0]      far;

  logic             isWrite;
  logic [31:0]      readMux;

  assign isWrite = (opClass == OP_WRITE);

  // Read path sees the registers before this edge's write
  always_comb begin
    case (regIdx)
      REG_ID:     readMux = ID_CODE;
      REG_CTRL:   readMux = control;
      REG_TBASE:  readMux = tbase;
      REG_DOMAIN: readMux = domain;
      REG_FSR:    readMux = {{(32 - FSR_W){1'b0}}, fsr};
      REG_FAR:    readMux = far;
      default:    readMux = 32'd0;
    endcase
  end

  // Control, translation base and domain
  always_ff @(posedge clk) begin
    if (rst) begin
      control <= 32'd0;
      tbase   <= 32'd0;
      domain  <= 32'd0;
    end else if (isWrite) begin
      case (regIdx)
        // Unused control bits stay zero
        REG_CTRL:   control <= opData & CTRL_WMASK;
        REG_TBASE:  tbase   <= opData & TBASE_MASK;
        REG_DOMAIN: domain  <= opData;
        default: begin
          control <= control;
        end
      endcase
    end
  end

  // Fault status and address
  always_ff @(posedge clk) begin
    if (rst) begin
      fsr <= '0;
      far <= 32'd0;
    end else begin
      // MMU record lands first
      if (mmuFault) begin
        fsr <= faultStatus;
        far <= faultAddr;
      end
      // Core write to the same register overrides it
      if (isWrite && (regIdx == REG_FSR)) begin
        fsr <= opData[FSR_W-1:0];
      end
      if (isWrite && (regIdx == REG_FAR)) begin
        far <= opData;
      end
    end
  end

  // Stage register toward the result stage
  always_ff @(posedge clk) begin
    if (rst) begin
      exClass <= OP_NONE;
      exMaint <= MNT_NONE;
    end else begin
      exClass <= opClass;
      exMaint <= maintOp;
    end
  end

  // Read data only matters for reads
  always_ff @(posedge clk) begin
    exData <= readMux;
  end

  // Decode must have rejected writes to the ID register
  assert property (@(posedge clk) disable iff (rst)
    isWrite |-> (regIdx != REG_ID));

endmodule

`default_nettype wire

// ==== rtl/cp15Pkg.sv ====
`default_nettype none

package cp15Pkg;

  // MCR / MRC register transfer layout
  typedef struct packed {
    logic [3:0] cond;
    logic [3:0] classBits;
    logic [2:0] opc1;
    // High for MRC (coprocessor to core)
    logic       load;
    logic [3:0] crn;
    logic [3:0] rd;
    logic [3:0] cpNum;
    logic [2:0] opc2;
    // Always set for a register transfer
    logic       one;
    logic [3:0] crm;
  } regXfer_s;

  // CDP data operation layout
  typedef struct packed {
    logic [3:0] cond;
    logic [3:0] classBits;
    logic [3:0] opc1;
    logic [3:0] crn;
    logic [3:0] crd;
    logic [3:0] cpNum;
    logic [2:0] opc2;
    // Clear for a data operation
    logic       zero;
    logic [3:0] crm;
  } dataOp_s;

  // One coprocessor word seen through both formats
  typedef union packed {
    regXfer_s regXfer;
    dataOp_s  dataOp;
  } cpWord_u;

  // Class bits shared by all coprocessor words
  localparam logic [3:0] CLASS_COPROC = 4'b1110;
  localparam logic [3:0] CP_NUM_SYS   = 4'd15;

  // Operation classes carried down the pipe
  localparam logic [2:0] OP_NONE  = 3'd0;
  localparam logic [2:0] OP_READ  = 3'd1;
  localparam logic [2:0] OP_WRITE = 3'd2;
  localparam logic [2:0] OP_MAINT = 3'd3;
  localparam logic [2:0] OP_UNDEF = 3'd4;

  // Register indices, same as the crn field
  localparam logic [3:0] REG_ID     = 4'd0;
  localparam logic [3:0] REG_CTRL   = 4'd1;
  localparam logic [3:0] REG_TBASE  = 4'd2;
  localparam logic [3:0] REG_DOMAIN = 4'd3;
  localparam logic [3:0] REG_FSR    = 4'd5;
  localparam logic [3:0] REG_FAR    = 4'd6;
  localparam logic [3:0] REG_CACHE  = 4'd7;
  localparam logic [3:0] REG_TLB    = 4'd8;

  // Cache and TLB maintenance codes
  localparam logic [2:0] MNT_NONE     = 3'd0;
  localparam logic [2:0] MNT_FLUSH_I  = 3'd1;
  localparam logic [2:0] MNT_FLUSH_D  = 3'd2;
  localparam logic [2:0] MNT_FLUSH_ID = 3'd3;
  localparam logic [2:0] MNT_CLEAN_D  = 3'd4;
  localparam logic [2:0] MNT_TLB_I    = 3'd5;
  localparam logic [2:0] MNT_TLB_D    = 3'd6;
  localparam logic [2:0] MNT_TLB_ID   = 3'd7;

  // Fixed identification word for c0
  localparam logic [31:0] ID_CODE = 32'h4101_A150;

  // Writable control bits: M A C W, B S R, I V
  localparam logic [31:0] CTRL_WMASK = 32'h0000_338F;

  // Translation base is 16 KB aligned
  localparam logic [31:0] TBASE_MASK = 32'hFFFF_C000;

  localparam int FSR_W = 8;

endpackage

`default_nettype wire

// ==== rtl/cp15Result.sv ====
`timescale 1ns/1ns
`default_nettype none

module cp15Result
  import cp15Pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic [2:0]  exClass,
  input  logic [2:0]  exMaint,
  input  logic [31:0] exData,
  output logic [31:0] rdData,
  output logic        rdValid,
  output logic        undef,
  output logic        flushI,
  output logic        flushD,
  output logic        cleanD,
  output logic        tlbFlushI,
  output logic        tlbFlushD
);

  logic       isMaint;
  // Pulse set, order is flushI flushD cleanD tlbFlushI tlbFlushD
  logic [4:0] pulseNext;

  assign isMaint = (exClass == OP_MAINT);

  // Expand each code, "both" codes set two bits
  always_comb begin
    pulseNext = 5'b00000;
    if (isMaint) begin
      case (exMaint)
        MNT_FLUSH_I:  pulseNext = 5'b10000;
        MNT_FLUSH_D:  pulseNext = 5'b01000;
        MNT_FLUSH_ID: pulseNext = 5'b11000;
        MNT_CLEAN_D:  pulseNext = 5'b00100;
        MNT_TLB_I:    pulseNext = 5'b00010;
        MNT_TLB_D:    pulseNext = 5'b00001;
        MNT_TLB_ID:   pulseNext = 5'b00011;
        default:      pulseNext = 5'b00000;
      endcase
    end
  end

  // Strobes and pulses, high for one cycle only
  always_ff @(posedge clk) begin
    if (rst) begin
      rdValid   <= 1'b0;
      undef     <= 1'b0;
      flushI    <= 1'b0;
      flushD    <= 1'b0;
      cleanD    <= 1'b0;
      tlbFlushI <= 1'b0;
      tlbFlushD <= 1'b0;
    end else begin
      rdValid   <= (exClass == OP_READ);
      undef     <= (exClass == OP_UNDEF);
      flushI    <= pulseNext[4];
      flushD    <= pulseNext[3];
      cleanD    <= pulseNext[2];
      tlbFlushI <= pulseNext[1];
      tlbFlushD <= pulseNext[0];
    end
  end

  // Qualified by rdValid
  always_ff @(posedge clk) begin
    rdData <= exData;
  end

  // A word is either read or rejected, never both
  assert property (@(posedge clk) disable iff (rst)
    !(rdValid && undef));

endmodule

`default_nettype wire

// ==== rtl/cp15Top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cp15Top
  import cp15Pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  // Core side, from the memory stage
  input  logic        cpEn,
  input  cpWord_u     cpInstr,
  input  logic [31:0] wrData,
  // MMU fault record
  input  logic        mmuFault,
  input  logic [7:0]  faultStatus,
  input  logic [31:0] faultAddr,
  // Read result
  output logic [31:0] rdData,
  output logic        rdValid,
  output logic        undef,
  // Cache and TLB maintenance pulses
  output logic        flushI,
  output logic        flushD,
  output logic        cleanD,
  output logic        tlbFlushI,
  output logic        tlbFlushD,
  // Levels toward the caches and MMU
  output logic [31:0] control,
  output logic [31:0] tbase,
  output logic [31:0] domain
);

  // Decode to execute
  logic [2:0]  opClass;
  logic [3:0]  regIdx;
  logic [2:0]  maintOp;
  logic [31:0] opData;

  // Execute to result
  logic [2:0]  exClass;
  logic [2:0]  exMaint;
  logic [31:0] exData;

  cp15Decode decode (.clk(clk), .rst(rst), .cpEn(cpEn), .cpInstr(cpInstr), .wrData(wrData),
                     .opClass(opClass), .regIdx(regIdx), .maintOp(maintOp),
                     .opData(opData));

  cp15Execute execute (.clk(clk), .rst(rst), .opClass(opClass), .regIdx(regIdx),
                       .maintOp(maintOp), .opData(opData), .mmuFault(mmuFault),
                       .faultStatus(faultStatus), .faultAddr(faultAddr),
                       .control(control), .tbase(tbase), .domain(domain),
                       .exClass(exClass), .exMaint(exMaint), .exData(exData));

  cp15Result result (.clk(clk), .rst(rst), .exClass(exClass), .exMaint(exMaint),
                     .exData(exData), .rdData(rdData), .rdValid(rdValid), .undef(undef),
                     .flushI(flushI), .flushD(flushD), .cleanD(cleanD),
                     .tlbFlushI(tlbFlushI), .tlbFlushD(tlbFlushD));

endmodule

`default_nettype wire

// ==== tests/cp15Tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cp15Tb
  import cp15Pkg::*;
();

  localparam int NUM_CYCLES    = 3000;
  localparam int RESET_TIMEOUT = 50;

  // One instruction as the model tracks it through decode and execute
  typedef struct packed {
    logic [2:0]  cls;
    logic [2:0]  mnt;
    logic [3:0]  regIdx;
    logic [31:0] wdata;
    logic [31:0] rdata;
  } op_t;

  logic        clk;
  logic        rst;
  logic        cpEn;
  cpWord_u     cpInstr;
  logic [31:0] wrData;
  logic        mmuFault;
  logic [7:0]  faultStatus;
  logic [31:0] faultAddr;
  logic [31:0] rdData;
  logic        rdValid;
  logic        undef;
  logic        flushI;
  logic        flushD;
  logic        cleanD;
  logic        tlbFlushI;
  logic        tlbFlushD;
  logic [31:0] control;
  logic [31:0] tbase;
  logic [31:0] domain;

  // Model registers and the decode/execute pipe
  // Entry 0 is the op whose result comes out next
  logic [31:0] mCtrl;
  logic [31:0] mTbase;
  logic [31:0] mDomain;
  logic [7:0]  mFsr;
  logic [31:0] mFar;
  op_t         pipe[$];
  op_t         expRes;

  cp15Top u_dut (.clk(clk), .rst(rst), .cpEn(cpEn), .cpInstr(cpInstr), .wrData(wrData),
                 .mmuFault(mmuFault), .faultStatus(faultStatus), .faultAddr(faultAddr),
                 .rdData(rdData), .rdValid(rdValid), .undef(undef), .flushI(flushI),
                 .flushD(flushD), .cleanD(cleanD), .tlbFlushI(tlbFlushI),
                 .tlbFlushD(tlbFlushD), .control(control), .tbase(tbase), .domain(domain));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held for 8 rising edges and released on a falling edge
  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  task automatic stopOnError(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Bit order flushI flushD cleanD tlbFlushI tlbFlushD
  task automatic checkPulses(input logic [4:0] got, input logic [4:0] exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL pulses got 0x%02h expected 0x%02h", got, exp));
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stopOnError($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // Classification straight from the decode rules
  function automatic void classify(input cpWord_u w, input logic en,
                                   output logic [2:0] cls, output logic [2:0] mnt);
    logic [3:0] crn;
    logic       isRead;
    logic       maintReg;
    logic       bad;
    crn      = w.regXfer.crn;
    isRead   = w.regXfer.load;
    maintReg = (crn == REG_CACHE) || (crn == REG_TLB);
    mnt      = MNT_NONE;
    if (crn == REG_CACHE && !isRead) begin
      if (w.regXfer.crm == 4'd5) mnt = MNT_FLUSH_I;
      if (w.regXfer.crm == 4'd6) mnt = MNT_FLUSH_D;
      if (w.regXfer.crm == 4'd7) mnt = MNT_FLUSH_ID;
      if (w.regXfer.crm == 4'd10) mnt = MNT_CLEAN_D;
    end
    if (crn == REG_TLB && !isRead) begin
      if (w.regXfer.crm == 4'd5) mnt = MNT_TLB_I;
      if (w.regXfer.crm == 4'd6) mnt = MNT_TLB_D;
      if (w.regXfer.crm == 4'd7) mnt = MNT_TLB_ID;
    end
    bad = (w.regXfer.classBits != CLASS_COPROC) || (w.regXfer.cpNum != CP_NUM_SYS) ||
          !w.dataOp.zero || (w.regXfer.opc1 != 3'd0) ||
          !(crn inside {4'd0, 4'd1, 4'd2, 4'd3, 4'd5, 4'd6, 4'd7, 4'd8}) ||
          (!isRead && crn == REG_ID) || (isRead && maintReg) ||
          (!isRead && maintReg && mnt == MNT_NONE);
    if (!en) begin
      cls = OP_NONE;
      mnt = MNT_NONE;
    end else if (bad) begin
      cls = OP_UNDEF;
      mnt = MNT_NONE;
    end else if (maintReg) begin
      cls = OP_MAINT;
    end else begin
      cls = isRead ? OP_READ : OP_WRITE;
    end
  endfunction

  function automatic logic [4:0] pulsesFor(input logic [2:0] cls, input logic [2:0] mnt);
    logic isM;
    isM = (cls == OP_MAINT);
    return {isM && (mnt == MNT_FLUSH_I || mnt == MNT_FLUSH_ID),
            isM && (mnt == MNT_FLUSH_D || mnt == MNT_FLUSH_ID),
            isM && (mnt == MNT_CLEAN_D),
            isM && (mnt == MNT_TLB_I || mnt == MNT_TLB_ID),
            isM && (mnt == MNT_TLB_D || mnt == MNT_TLB_ID)};
  endfunction

  function automatic logic [31:0] readModel(input logic [3:0] idx);
    case (idx)
      REG_ID:     return ID_CODE;
      REG_CTRL:   return mCtrl;
      REG_TBASE:  return mTbase;
      REG_DOMAIN: return mDomain;
      REG_FSR:    return {24'd0, mFsr};
      REG_FAR:    return mFar;
      default:    return 32'd0;
    endcase
  endfunction

  // Mostly legal CP15 transfers with each undefined kind mixed in
  function automatic cpWord_u makeWord();
    cpWord_u w;
    w = cpWord_u'($urandom);
    w.regXfer.classBits = CLASS_COPROC;
    w.regXfer.cpNum     = CP_NUM_SYS;
    w.regXfer.opc1      = 3'd0;
    w.regXfer.one       = 1'b1;
    case ($urandom_range(0, 7))
      0:       w.regXfer.crn = REG_ID;
      1:       w.regXfer.crn = REG_CTRL;
      2:       w.regXfer.crn = REG_TBASE;
      3:       w.regXfer.crn = REG_DOMAIN;
      4:       w.regXfer.crn = REG_FSR;
      5:       w.regXfer.crn = REG_FAR;
      6:       w.regXfer.crn = REG_CACHE;
      default: w.regXfer.crn = REG_TLB;
    endcase
    // Listed crm values most of the time
    case ($urandom_range(0, 4))
      0:       w.regXfer.crm = 4'd5;
      1:       w.regXfer.crm = 4'd6;
      2:       w.regXfer.crm = 4'd7;
      3:       w.regXfer.crm = 4'd10;
      default: w.regXfer.crm = 4'($urandom);
    endcase
    case ($urandom_range(0, 19))
      0:       w.regXfer.classBits = 4'($urandom);
      1:       w.regXfer.cpNum = 4'($urandom);
      2:       w.dataOp.zero = 1'b0;
      3:       w.regXfer.opc1 = 3'($urandom_range(1, 7));
      4:       w.regXfer.crn = 4'($urandom);
      default: ;
    endcase
    return w;
  endfunction

  task automatic checkOutputs();
    checkFlag("rdValid", rdValid, expRes.cls == OP_READ);
    checkFlag("undef", undef, expRes.cls == OP_UNDEF);
    checkPulses({flushI, flushD, cleanD, tlbFlushI, tlbFlushD},
                pulsesFor(expRes.cls, expRes.mnt));
    if (expRes.cls == OP_READ) begin
      checkWord("rdData", rdData, expRes.rdata);
    end
    checkWord("control", control, mCtrl);
    checkWord("tbase", tbase, mTbase);
    checkWord("domain", domain, mDomain);
  endtask

  // Drive one cycle of inputs and advance the model over the next rising edge
  task automatic driveCycle(input logic idle);
    op_t ex;
    op_t nu;
    cpEn        = idle ? 1'b0 : ($urandom_range(0, 9) != 0);
    cpInstr     = makeWord();
    wrData      = $urandom;
    mmuFault    = idle ? 1'b0 : ($urandom_range(0, 3) == 0);
    faultStatus = 8'($urandom);
    faultAddr   = $urandom;
    expRes = pipe.pop_front();
    ex = pipe.pop_front();
    // Read sees registers before this edge
    ex.rdata = readModel(ex.regIdx);
    if (mmuFault) begin
      mFsr = faultStatus;
      mFar = faultAddr;
    end
    // Core write wins over a fault in the same edge
    if (ex.cls == OP_WRITE) begin
      case (ex.regIdx)
        REG_CTRL:   mCtrl = ex.wdata & CTRL_WMASK;
        REG_TBASE:  mTbase = ex.wdata & TBASE_MASK;
        REG_DOMAIN: mDomain = ex.wdata;
        REG_FSR:    mFsr = ex.wdata[7:0];
        REG_FAR:    mFar = ex.wdata;
        default:    ;
      endcase
    end
    pipe.push_back(ex);
    classify(cpInstr, cpEn, nu.cls, nu.mnt);
    nu.regIdx = cpInstr.regXfer.crn;
    nu.wdata  = wrData;
    nu.rdata  = 32'd0;
    pipe.push_back(nu);
  endtask

  initial begin
    int  waitCount;
    op_t empty;
    cpEn        = 1'b0;
    cpInstr     = '0;
    wrData      = 32'd0;
    mmuFault    = 1'b0;
    faultStatus = 8'd0;
    faultAddr   = 32'd0;
    void'($urandom(32'h6b981901));
    waitCount   = 0;
    while (rst !== 1'b0) begin
      @(posedge clk);
      waitCount++;
      if (waitCount > RESET_TIMEOUT) begin
        stopOnError("Timed out waiting for reset to be released");
      end
    end
    @(negedge clk);
    // Everything starts from the reset state
    empty   = '0;
    expRes  = empty;
    mCtrl   = 32'd0;
    mTbase  = 32'd0;
    mDomain = 32'd0;
    mFsr    = 8'd0;
    mFar    = 32'd0;
    pipe.push_back(empty);
    pipe.push_back(empty);
    for (int cyc = 0; cyc < NUM_CYCLES + 3; cyc++) begin
      checkOutputs();
      driveCycle(cyc >= NUM_CYCLES);
      @(negedge clk);
    end
    checkOutputs();
    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
